/* axi_pkg.sv */
package axi_pkg;

    ////////////////////////////////////////////////////////////
    // Field widths
    ////////////////////////////////////////////////////////////

    typedef logic [31:0] axi_addr_t;
    typedef logic [63:0] axi_data_t;
    typedef logic [7:0]  axi_strb_t;
    typedef logic [7:0]  axi_len_t;
    typedef logic [2:0]  axi_size_t;
    typedef logic [1:0]  axi_burst_t;
    typedef logic [1:0]  axi_resp_t;
    typedef logic [3:0]  axi_id_t;

    // Protocol codes
    localparam axi_resp_t   RESP_OKAY  = 2'b00;
    localparam axi_burst_t  BURST_INCR = 2'b01;
    localparam axi_size_t   SIZE_8B    = 3'b011;
    localparam int unsigned BEAT_BYTES = 8;
    // Longest burst, 256 beats
    localparam axi_len_t    MAX_LEN    = 8'd255;

    ////////////////////////////////////////////////////////////
    // Channel payloads, ready travels separately
    ////////////////////////////////////////////////////////////

    // Shared by AW and AR
    typedef struct packed {
        logic       valid;
        axi_id_t    id;
        axi_addr_t  addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
    } addr_req_t;

    typedef struct packed {
        logic      valid;
        axi_data_t data;
        axi_strb_t strb;
        logic      last;
    } wdata_t;

    typedef struct packed {
        logic      valid;
        axi_resp_t resp;
    } bresp_t;

    typedef struct packed {
        logic      valid;
        axi_id_t   id;
        axi_data_t data;
        axi_resp_t resp;
        logic      last;
    } rdata_t;

endpackage

/* dma_scan_top.sv */
module dma_scan_top (
    input  logic                  axi_clk,
    input  logic                  axi_reset,

    // Host access to on-chip registers
    input  axi_pkg::addr_req_t    i_m_aw,
    output logic                  o_m_awready,
    input  axi_pkg::wdata_t       i_m_w,
    output logic                  o_m_wready,
    output axi_pkg::bresp_t       o_m_b,
    input  logic                  i_m_bready,
    input  axi_pkg::addr_req_t    i_m_ar,
    output logic                  o_m_arready,
    output axi_pkg::rdata_t       o_m_r,
    input  logic                  i_m_rready,

    // Reads of host memory
    output axi_pkg::addr_req_t    o_s_ar,
    input  logic                  i_s_arready,
    input  axi_pkg::rdata_t       i_s_r,
    output logic                  o_s_rready,

    output logic                  o_scan_enable,
    output scan_pkg::perf_stats_t o_stats
);

    logic ar_fire;
    logic r_fire;

    mmio_decode u_decode (
        .axi_clk       (axi_clk),
        .axi_reset     (axi_reset),
        .i_m_aw        (i_m_aw),
        .o_m_awready   (o_m_awready),
        .i_m_w         (i_m_w),
        .o_m_wready    (o_m_wready),
        .o_m_b         (o_m_b),
        .i_m_bready    (i_m_bready),
        .i_m_ar        (i_m_ar),
        .o_m_arready   (o_m_arready),
        .o_m_r         (o_m_r),
        .i_m_rready    (i_m_rready),
        .o_scan_enable (o_scan_enable)
    );

    scan_execute u_execute (
        .axi_clk       (axi_clk),
        .axi_reset     (axi_reset),
        .i_scan_enable (o_scan_enable),
        .o_s_ar        (o_s_ar),
        .i_s_arready   (i_s_arready),
        .o_s_rready    (o_s_rready)
    );

    // Transfer strobes on the host memory side
    assign ar_fire = o_s_ar.valid && i_s_arready;
    assign r_fire  = i_s_r.valid && o_s_rready;

    perf_result u_result (
        .axi_clk   (axi_clk),
        .axi_reset (axi_reset),
        .i_ar_fire (ar_fire),
        .i_r_fire  (r_fire),
        .o_stats   (o_stats)
    );

endmodule

/* mmio_decode.sv */
module mmio_decode (
    input  logic               axi_clk,
    input  logic               axi_reset,

    input  axi_pkg::addr_req_t i_m_aw,
    output logic               o_m_awready,
    input  axi_pkg::wdata_t    i_m_w,
    output logic               o_m_wready,
    output axi_pkg::bresp_t    o_m_b,
    input  logic               i_m_bready,

    input  axi_pkg::addr_req_t i_m_ar,
    output logic               o_m_arready,
    output axi_pkg::rdata_t    o_m_r,
    input  logic               i_m_rready,

    output logic               o_scan_enable
);
    import axi_pkg::*;
    import scan_pkg::*;

    logic    r_pending;
    axi_id_t r_id;
    logic    ar_fire;

    logic    b_pending;
    logic    wr_fire;
    logic    ctrl_hit;

    logic    scan_enable;

    ////////////////////////////////////////////////////////////
    // Read channel
    ////////////////////////////////////////////////////////////

    // One read in flight, a stalled R blocks AR
    assign o_m_arready = !r_pending;
    assign ar_fire     = i_m_ar.valid && o_m_arready;

    always_ff @(posedge axi_clk) begin
        if (axi_reset) begin
            r_pending <= 1'b0;
        end else if (r_pending && i_m_rready) begin
            r_pending <= 1'b0;
        end else if (ar_fire) begin
            r_pending <= 1'b1;
        end
    end

    // Echo the request id on the reply
    always_ff @(posedge axi_clk) begin
        if (ar_fire) begin
            r_id <= i_m_ar.id;
        end
    end

    assign o_m_r = '{valid: r_pending, id: r_id, data: READ_PATTERN,
                     resp: RESP_OKAY, last: 1'b1};

    ////////////////////////////////////////////////////////////
    // Write channel
    ////////////////////////////////////////////////////////////

    // AW and W are taken together, only when both are offered
    assign wr_fire     = i_m_aw.valid && i_m_w.valid && !b_pending;
    assign o_m_awready = wr_fire;
    assign o_m_wready  = wr_fire;

    always_ff @(posedge axi_clk) begin
        if (axi_reset) begin
            b_pending <= 1'b0;
        end else if (b_pending && i_m_bready) begin
            b_pending <= 1'b0;
        end else if (wr_fire) begin
            b_pending <= 1'b1;
        end
    end

    assign o_m_b = '{valid: b_pending, resp: RESP_OKAY};

    // Control register, each accepted write to it flips the scan enable
    assign ctrl_hit = wr_fire && (i_m_aw.addr == CTRL_ADDR);

    always_ff @(posedge axi_clk) begin
        if (axi_reset) begin
            scan_enable <= 1'b0;
        end else if (ctrl_hit) begin
            scan_enable <= !scan_enable;
        end
    end

    assign o_scan_enable = scan_enable;

endmodule

/* perf_result.sv */
module perf_result (
    input  logic                  axi_clk,
    input  logic                  axi_reset,

    input  logic                  i_ar_fire,
    input  logic                  i_r_fire,

    output scan_pkg::perf_stats_t o_stats
);
    import axi_pkg::*;
    import scan_pkg::*;

    tick_count_t   tick_count;
    logic          second_tick;
    seconds_t      seconds;

    window_bytes_t ar_inc;
    window_bytes_t r_inc;

    total_bytes_t  ar_bytes;
    total_bytes_t  r_bytes;
    window_bytes_t ar_acc_bytes;
    window_bytes_t r_acc_bytes;
    window_bytes_t ar_sec_bytes;
    window_bytes_t r_sec_bytes;

    ////////////////////////////////////////////////////////////
    // Second tick
    ////////////////////////////////////////////////////////////

    assign second_tick = (tick_count == tick_count_t'(TICK_PERIOD - 1));

    always_ff @(posedge axi_clk) begin
        if (axi_reset) begin
            tick_count <= '0;
            seconds    <= '0;
        end else if (second_tick) begin
            tick_count <= '0;
            seconds    <= seconds + 1'b1;
        end else begin
            tick_count <= tick_count + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Byte counters
    ////////////////////////////////////////////////////////////

    // Each request asks for a full burst, each beat is one bus word
    assign ar_inc = i_ar_fire ? window_bytes_t'(BURST_BYTES) : '0;
    assign r_inc  = i_r_fire  ? window_bytes_t'(BEAT_BYTES)  : '0;

    always_ff @(posedge axi_clk) begin
        if (axi_reset) begin
            ar_bytes     <= '0;
            r_bytes      <= '0;
            ar_acc_bytes <= '0;
            r_acc_bytes  <= '0;
            ar_sec_bytes <= '0;
            r_sec_bytes  <= '0;
        end else begin
            ar_bytes <= ar_bytes + total_bytes_t'(ar_inc);
            r_bytes  <= r_bytes + total_bytes_t'(r_inc);
            // On the tick the window restarts with this cycle's transfer
            if (second_tick) begin
                ar_sec_bytes <= ar_acc_bytes;
                r_sec_bytes  <= r_acc_bytes;
                ar_acc_bytes <= ar_inc;
                r_acc_bytes  <= r_inc;
            end else begin
                ar_acc_bytes <= ar_acc_bytes + ar_inc;
                r_acc_bytes  <= r_acc_bytes + r_inc;
            end
        end
    end

    assign o_stats = '{seconds: seconds, ar_bytes: ar_bytes, r_bytes: r_bytes,
                       ar_sec_bytes: ar_sec_bytes, r_sec_bytes: r_sec_bytes};

endmodule

/* run.sh */
#!/usr/bin/env bash
# Compile the testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dma_scan -f tb.f -o tb_dma_scan_sim

# A failed assertion stops the model early, the log search still decides
./obj_dir/tb_dma_scan_sim | tee "$LOG"

if grep -qx '>>> PASS' "$LOG"; then
    echo "run.sh: simulation passed"
else
    echo "run.sh: simulation failed, see $LOG"
    exit 1
fi

/* scan_execute.sv */
module scan_execute (
    input  logic               axi_clk,
    input  logic               axi_reset,

    input  logic               i_scan_enable,

    output axi_pkg::addr_req_t o_s_ar,
    input  logic               i_s_arready,
    output logic               o_s_rready
);
    import axi_pkg::*;
    import scan_pkg::*;

    ar_timer_t ar_timer;
    logic      timer_expired;

    logic      ar_valid;
    axi_addr_t ar_addr;
    logic      ar_fire;

    ////////////////////////////////////////////////////////////
    // Issue timer
    ////////////////////////////////////////////////////////////

    assign timer_expired = (ar_timer == '0);

    always_ff @(posedge axi_clk) begin
        if (axi_reset) begin
            ar_timer <= ar_timer_t'(AR_PERIOD);
        end else if (timer_expired) begin
            ar_timer <= ar_timer_t'(AR_PERIOD);
        end else begin
            ar_timer <= ar_timer - 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read request generator
    ////////////////////////////////////////////////////////////

    assign ar_fire = ar_valid && i_s_arready;

    // Request held until the host side accepts it
    always_ff @(posedge axi_clk) begin
        if (axi_reset) begin
            ar_valid <= 1'b0;
        end else if (timer_expired && i_scan_enable) begin
            ar_valid <= 1'b1;
        end else if (ar_fire) begin
            ar_valid <= 1'b0;
        end
    end

    // Walk host memory one burst at a time
    always_ff @(posedge axi_clk) begin
        if (axi_reset) begin
            ar_addr <= '0;
        end else if (ar_fire) begin
            ar_addr <= ar_addr + axi_addr_t'(BURST_BYTES);
        end
    end

    assign o_s_ar = '{valid: ar_valid, id: axi_id_t'(0), addr: ar_addr,
                      len: MAX_LEN, size: SIZE_8B, burst: BURST_INCR};

    // Returned data is dropped, so never stall it
    assign o_s_rready = 1'b1;

endmodule

/* scan_pkg.sv */
package scan_pkg;

    ////////////////////////////////////////////////////////////
    // Host register map and responder
    ////////////////////////////////////////////////////////////

    // Write here toggles the scanner
    localparam axi_pkg::axi_addr_t CTRL_ADDR    = 32'h0000_CCCC;
    localparam axi_pkg::axi_data_t READ_PATTERN = 64'h0000_1234_5678_0000;

    ////////////////////////////////////////////////////////////
    // Scanner and counter timing
    ////////////////////////////////////////////////////////////

    // Bytes moved by one full-length burst
    localparam int unsigned BURST_BYTES = (axi_pkg::MAX_LEN + 1) * axi_pkg::BEAT_BYTES;

    // Issue timer reload, one request slot every 64 cycles
    localparam int unsigned AR_PERIOD  = 63;
    localparam int unsigned AR_TIMER_W = $clog2(AR_PERIOD + 1);

    // Cycles per simulated second
    localparam int unsigned TICK_PERIOD = 1000;
    localparam int unsigned TICK_W      = $clog2(TICK_PERIOD);

    typedef logic [AR_TIMER_W-1:0] ar_timer_t;
    typedef logic [TICK_W-1:0]     tick_count_t;

    typedef logic [47:0] total_bytes_t;
    typedef logic [31:0] window_bytes_t;
    typedef logic [31:0] seconds_t;

    typedef struct packed {
        seconds_t      seconds;
        total_bytes_t  ar_bytes;
        total_bytes_t  r_bytes;
        window_bytes_t ar_sec_bytes;
        window_bytes_t r_sec_bytes;
    } perf_stats_t;

endpackage

/* tb.f */
axi_pkg.sv
scan_pkg.sv
mmio_decode.sv
scan_execute.sv
perf_result.sv
dma_scan_top.sv
tb_dma_scan_assert.sv
tb_dma_scan.sv

/* tb_dma_scan.sv */
module tb_dma_scan;
    import axi_pkg::*;
    import scan_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;

    logic        axi_clk;
    logic        axi_reset;
    addr_req_t   i_m_aw;
    logic        o_m_awready;
    wdata_t      i_m_w;
    logic        o_m_wready;
    bresp_t      o_m_b;
    logic        i_m_bready;
    addr_req_t   i_m_ar;
    logic        o_m_arready;
    rdata_t      o_m_r;
    logic        i_m_rready;
    addr_req_t   o_s_ar;
    logic        i_s_arready;
    rdata_t      i_s_r;
    logic        o_s_rready;
    logic        o_scan_enable;
    perf_stats_t o_stats;

    logic [31:0] rng_state;
    int          error_count;
    int          tests_run;
    int          tests_failed;

    // Observed traffic kept by the compare process
    longint unsigned ar_count;
    longint unsigned r_count;
    longint unsigned win_ar_n;
    longint unsigned win_r_n;
    logic            ar_fire_now;
    logic            r_fire_now;
    logic            last_ar_fire;
    logic            last_r_fire;
    logic            ar_held;
    axi_addr_t       held_addr;
    logic            prev_valid;
    logic            prev_enable;
    seconds_t        last_seconds;
    int              since_tick;
    int              tick_checks;

    dma_scan_top uut (.*);

    initial axi_clk = 1'b0;
    always #4 axi_clk = ~axi_clk;

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Bytes for a number of scanner requests or returned beats
    function automatic longint unsigned expected_bytes(input logic is_request,
                                                       input longint unsigned transfers);
        if (is_request) begin
            return transfers * BURST_BYTES;
        end
        return transfers * BEAT_BYTES;
    endfunction

    task automatic report_mismatch(input string name, input logic [191:0] got,
                                   input logic [191:0] exp);
        $display("mismatch at time %0t: %s got %0h, expected %0h", $time, name, got, exp);
        error_count++;
    endtask

    task automatic report_error(input string msg);
        $display("error at time %0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic close_test(input string name, input int errs_before);
        tests_run++;
        if (error_count == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: failed, %0d errors", tests_run, name,
                     error_count - errs_before);
            tests_failed++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Compare process
    ////////////////////////////////////////////////////////////

    always @(posedge axi_clk) begin
        if (axi_reset) begin
            ar_count     = 0;
            r_count      = 0;
            win_ar_n     = 0;
            win_r_n      = 0;
            last_ar_fire = 1'b0;
            last_r_fire  = 1'b0;
            ar_held      = 1'b0;
            prev_valid   = 1'b0;
            prev_enable  = 1'b0;
            last_seconds = '0;
            since_tick   = 0;
            tick_checks  = 0;
        end else begin
            // Totals trail the transfers by one register
            if (o_stats.ar_bytes != expected_bytes(1'b1, ar_count)) begin
                report_mismatch("o_stats.ar_bytes", o_stats.ar_bytes,
                                expected_bytes(1'b1, ar_count));
            end
            if (o_stats.r_bytes != expected_bytes(1'b0, r_count)) begin
                report_mismatch("o_stats.r_bytes", o_stats.r_bytes,
                                expected_bytes(1'b0, r_count));
            end
            if (o_stats.seconds != last_seconds) begin
                if (o_stats.seconds != last_seconds + 1) begin
                    report_mismatch("o_stats.seconds", o_stats.seconds, last_seconds + 1);
                end
                if (since_tick != TICK_PERIOD) begin
                    report_error($sformatf("second tick came after %0d cycles", since_tick));
                end
                // The transfer on the tick edge opens the next window
                if (o_stats.ar_sec_bytes != expected_bytes(1'b1, win_ar_n - last_ar_fire)) begin
                    report_mismatch("o_stats.ar_sec_bytes", o_stats.ar_sec_bytes,
                                    expected_bytes(1'b1, win_ar_n - last_ar_fire));
                end
                if (o_stats.r_sec_bytes != expected_bytes(1'b0, win_r_n - last_r_fire)) begin
                    report_mismatch("o_stats.r_sec_bytes", o_stats.r_sec_bytes,
                                    expected_bytes(1'b0, win_r_n - last_r_fire));
                end
                win_ar_n     = last_ar_fire;
                win_r_n      = last_r_fire;
                last_seconds = o_stats.seconds;
                since_tick   = 0;
                tick_checks++;
            end
            since_tick++;

            ar_fire_now = o_s_ar.valid && i_s_arready;
            r_fire_now  = i_s_r.valid && o_s_rready;
            if (ar_held && (!o_s_ar.valid || o_s_ar.addr != held_addr)) begin
                report_error("scanner request dropped or moved before ready");
            end
            if (o_s_ar.valid && !prev_valid && !prev_enable) begin
                report_error("scanner request raised while disabled");
            end
            if (o_s_ar.valid) begin
                if (o_s_ar.addr != axi_addr_t'(expected_bytes(1'b1, ar_count))) begin
                    report_mismatch("o_s_ar.addr", o_s_ar.addr,
                                    axi_addr_t'(expected_bytes(1'b1, ar_count)));
                end
                if ({o_s_ar.id, o_s_ar.len, o_s_ar.size, o_s_ar.burst} !=
                    {4'd0, MAX_LEN, SIZE_8B, BURST_INCR}) begin
                    report_mismatch("o_s_ar.{id,len,size,burst}",
                                    {o_s_ar.id, o_s_ar.len, o_s_ar.size, o_s_ar.burst},
                                    {4'd0, MAX_LEN, SIZE_8B, BURST_INCR});
                end
            end
            if (!o_s_rready) begin
                report_mismatch("o_s_rready", o_s_rready, 1'b1);
            end
            ar_held      = o_s_ar.valid && !i_s_arready;
            held_addr    = o_s_ar.addr;
            prev_valid   = o_s_ar.valid;
            prev_enable  = o_scan_enable;
            ar_count     += ar_fire_now;
            r_count      += r_fire_now;
            win_ar_n     += ar_fire_now;
            win_r_n      += r_fire_now;
            last_ar_fire = ar_fire_now;
            last_r_fire  = r_fire_now;
        end
    end

    ////////////////////////////////////////////////////////////
    // Host and memory side drivers
    ////////////////////////////////////////////////////////////

    // Back to back reads with a new request offered as soon as one is taken
    task automatic run_host_reads(input int n_reads);
        int          sent;
        int          got;
        int          cycles;
        axi_id_t     last_id;
        logic        ar_taken;
        logic [31:0] rnd;
        sent    = 0;
        got     = 0;
        cycles  = 0;
        last_id = '0;
        rnd     = next_random();
        @(negedge axi_clk);
        i_m_ar = '{valid: 1'b1, id: rnd[3:0], addr: {rnd[31:3], 3'b000}, len: '0,
                   size: SIZE_8B, burst: BURST_INCR};
        while (got < n_reads && cycles < TIMEOUT_CYCLES) begin
            rnd        = next_random();
            i_m_rready = (rnd[1:0] != 2'b00);
            @(posedge axi_clk);
            cycles++;
            ar_taken = i_m_ar.valid && o_m_arready;
            if (o_m_r.valid) begin
                if (o_m_r.data != READ_PATTERN) begin
                    report_mismatch("o_m_r.data", o_m_r.data, READ_PATTERN);
                end
                if ({o_m_r.resp, o_m_r.last} != {RESP_OKAY, 1'b1}) begin
                    report_mismatch("o_m_r.{resp,last}", {o_m_r.resp, o_m_r.last},
                                    {RESP_OKAY, 1'b1});
                end
                if (o_m_r.id != last_id) begin
                    report_mismatch("o_m_r.id", o_m_r.id, last_id);
                end
                if (o_m_arready) begin
                    report_error("read address accepted while a response is pending");
                end
                if (i_m_rready) begin
                    got++;
                end
            end
            if (ar_taken) begin
                last_id = i_m_ar.id;
                sent++;
            end
            @(negedge axi_clk);
            if (ar_taken) begin
                rnd          = next_random();
                i_m_ar.valid = (sent < n_reads);
                i_m_ar.id    = rnd[3:0];
                i_m_ar.addr  = {rnd[31:3], 3'b000};
            end
        end
        i_m_ar.valid = 1'b0;
        i_m_rready   = 1'b0;
        if (got < n_reads) begin
            report_error("timeout waiting for read responses");
        end
    endtask

    task automatic host_write(input axi_addr_t addr);
        int          cycles;
        logic        done;
        logic [31:0] rnd;
        rnd = next_random();
        @(negedge axi_clk);
        i_m_aw = '{valid: 1'b1, id: rnd[3:0], addr: addr, len: '0, size: SIZE_8B,
                   burst: BURST_INCR};
        i_m_w  = '{valid: 1'b1, data: {rnd, ~rnd}, strb: '1, last: 1'b1};
        cycles = 0;
        @(posedge axi_clk);
        while (!o_m_awready && cycles < TIMEOUT_CYCLES) begin
            @(posedge axi_clk);
            cycles++;
        end
        if (!o_m_awready) begin
            report_error("timeout waiting for write address ready");
        end
        if (!o_m_wready) begin
            report_mismatch("o_m_wready", o_m_wready, 1'b1);
        end
        @(negedge axi_clk);
        i_m_aw.valid = 1'b0;
        i_m_w.valid  = 1'b0;
        cycles       = 0;
        done         = 1'b0;
        while (!done && cycles < TIMEOUT_CYCLES) begin
            rnd        = next_random();
            i_m_bready = rnd[0];
            @(posedge axi_clk);
            cycles++;
            if (o_m_b.valid && i_m_bready) begin
                done = 1'b1;
                if (o_m_b.resp != RESP_OKAY) begin
                    report_mismatch("o_m_b.resp", o_m_b.resp, RESP_OKAY);
                end
            end
            @(negedge axi_clk);
        end
        i_m_bready = 1'b0;
        if (!done) begin
            report_error("timeout waiting for write response");
        end
    endtask

    // Random AR back-pressure and R beats until enough requests or ticks are seen
    task automatic drive_scan_traffic(input longint unsigned ar_target, input int tick_target);
        int          cycles;
        logic [31:0] rnd;
        cycles = 0;
        while ((ar_count < ar_target || tick_checks < tick_target) &&
               cycles < 8 * TICK_PERIOD) begin
            @(negedge axi_clk);
            rnd         = next_random();
            i_s_arready = rnd[4];
            i_s_r       = '{valid: rnd[5], id: '0, data: {rnd, ~rnd}, resp: RESP_OKAY,
                            last: rnd[9]};
            cycles++;
        end
        @(negedge axi_clk);
        i_s_r.valid = 1'b0;
        if (ar_count < ar_target || tick_checks < tick_target) begin
            report_error("timeout waiting for scanner traffic");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int        errs;
        int        cycles;
        int        assert_fails;
        logic      seen;
        axi_addr_t addr;
        rng_state    = 32'h7d13_0ab3;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        axi_reset    = 1'b1;
        i_m_aw       = '0;
        i_m_w        = '0;
        i_m_bready   = 1'b0;
        i_m_ar       = '0;
        i_m_rready   = 1'b0;
        i_s_arready  = 1'b0;
        i_s_r        = '0;
        repeat (10) @(negedge axi_clk);
        axi_reset = 1'b0;

        errs = error_count;
        @(negedge axi_clk);
        if ({o_m_r.valid, o_m_b.valid, o_s_ar.valid, o_scan_enable, o_m_awready,
             o_m_wready} != 6'b000000) begin
            report_mismatch("{r.valid,b.valid,s_ar.valid,enable,awready,wready}",
                            {o_m_r.valid, o_m_b.valid, o_s_ar.valid, o_scan_enable,
                             o_m_awready, o_m_wready}, '0);
        end
        if (o_stats != '0) begin
            report_mismatch("o_stats", o_stats, '0);
        end
        close_test("reset state", errs);

        errs = error_count;
        run_host_reads(16);
        close_test("host reads", errs);

        // Low address bits cleared so the control address is never hit
        errs = error_count;
        repeat (4) begin
            addr = next_random() & 32'hffff_fff8;
            host_write(addr);
            if (o_scan_enable != 1'b0) begin
                report_mismatch("o_scan_enable", o_scan_enable, 1'b0);
            end
        end
        host_write(CTRL_ADDR);
        if (o_scan_enable != 1'b1) begin
            report_mismatch("o_scan_enable", o_scan_enable, 1'b1);
        end
        host_write(CTRL_ADDR);
        if (o_scan_enable != 1'b0) begin
            report_mismatch("o_scan_enable", o_scan_enable, 1'b0);
        end
        close_test("host writes", errs);

        errs = error_count;
        host_write(CTRL_ADDR);
        drive_scan_traffic(ar_count + 12, 0);
        host_write(CTRL_ADDR);
        if (o_scan_enable != 1'b0) begin
            report_mismatch("o_scan_enable", o_scan_enable, 1'b0);
        end
        // Drain a request launched just before the disable
        i_s_arready = 1'b1;
        cycles      = 0;
        while (o_s_ar.valid && cycles < TIMEOUT_CYCLES) begin
            @(negedge axi_clk);
            cycles++;
        end
        if (o_s_ar.valid) begin
            report_error("timeout draining the last scanner request");
        end
        seen = 1'b0;
        repeat (4 * (AR_PERIOD + 1)) begin
            @(negedge axi_clk);
            seen = seen | o_s_ar.valid;
        end
        if (seen) begin
            report_error("scanner request seen with scanning disabled");
        end
        close_test("scanner requests", errs);

        errs = error_count;
        @(negedge axi_clk);
        if (o_stats.ar_bytes != expected_bytes(1'b1, ar_count)) begin
            report_mismatch("o_stats.ar_bytes", o_stats.ar_bytes,
                            expected_bytes(1'b1, ar_count));
        end
        if (o_stats.r_bytes != expected_bytes(1'b0, r_count)) begin
            report_mismatch("o_stats.r_bytes", o_stats.r_bytes,
                            expected_bytes(1'b0, r_count));
        end
        if (ar_count == 0 || r_count == 0) begin
            report_error("no scanner traffic was observed");
        end
        close_test("byte totals", errs);

        errs = error_count;
        host_write(CTRL_ADDR);
        drive_scan_traffic(0, tick_checks + 3);
        if (o_stats.ar_sec_bytes == 0 || o_stats.r_sec_bytes == 0) begin
            report_error("per-second window empty while traffic runs");
        end
        close_test("per-second windows", errs);

        assert_fails = uut.u_decode.u_decode_assert.fail_count +
                       uut.u_execute.u_execute_assert.fail_count;
        if (assert_fails != 0) begin
            report_error($sformatf("%0d protocol assertion failures", assert_fails));
        end

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* tb_dma_scan_assert.sv */
module tb_dma_scan_assert (
    input logic               axi_clk,
    input logic               axi_reset,
    input axi_pkg::addr_req_t i_ar,
    input logic               i_arready,
    input logic               i_aw_valid,
    input logic               i_w_valid,
    input logic               i_awready,
    input logic               i_wready,
    input logic               i_b_valid,
    input logic               i_r_valid
);

    int fail_count;

    initial fail_count = 0;

    // Request and its address held until the handshake
    a_ar_stable: assert property (@(posedge axi_clk) disable iff (axi_reset)
        (i_ar.valid && !i_arready) |=> (i_ar.valid && $stable(i_ar.addr)))
        else begin
            $error("AR valid or address changed before ready");
            fail_count++;
        end

    // Joint AW and W transfer leaves B pending and blocks the next write
    a_write_ready: assert property (@(posedge axi_clk) disable iff (axi_reset)
        (i_awready || i_wready) |=>
            ($past(i_aw_valid && i_w_valid && i_awready && i_wready) &&
             i_b_valid && !i_awready && !i_wready))
        else begin
            $error("write ready without both AW and W valid or B not pending after it");
            fail_count++;
        end

    // R valid only after an accepted read and AR held off while it is out
    a_one_read: assert property (@(posedge axi_clk) disable iff (axi_reset)
        i_r_valid |-> (!i_arready &&
                       ($past(i_r_valid) || $past(i_ar.valid && i_arready))))
        else begin
            $error("read response without a request or AR ready while it is pending");
            fail_count++;
        end

endmodule

// Only the request channel exists on the scanner
bind scan_execute tb_dma_scan_assert u_execute_assert (
    .axi_clk(axi_clk), .axi_reset(axi_reset),
    .i_ar(o_s_ar), .i_arready(i_s_arready),
    .i_aw_valid(1'b0), .i_w_valid(1'b0), .i_awready(1'b0), .i_wready(1'b0),
    .i_b_valid(1'b0), .i_r_valid(1'b0)
);

bind mmio_decode tb_dma_scan_assert u_decode_assert (
    .axi_clk(axi_clk), .axi_reset(axi_reset),
    .i_ar(i_m_ar), .i_arready(o_m_arready),
    .i_aw_valid(i_m_aw.valid), .i_w_valid(i_m_w.valid),
    .i_awready(o_m_awready), .i_wready(o_m_wready),
    .i_b_valid(o_m_b.valid), .i_r_valid(o_m_r.valid)
);
